/* logic/md_pkg.sv */
// shared types and widths for the multiply/divide unit; DATA_W is fixed at 32 for MIPS HI/LO
`default_nettype none

package md_pkg;

  // operand and HI/LO register width
  parameter int DATA_W = 32;

  // full product, split into HI and LO
  parameter int PROD_W = 2 * DATA_W;

  // multiplier operands after sign or zero extension
  parameter int EXT_W = DATA_W + 1;

  // operation presented with op_valid
  typedef enum logic [2:0] {
    op_mult  = 3'd0, // signed multiply
    op_multu = 3'd1, // unsigned multiply
    op_div   = 3'd2, // signed divide
    op_divu  = 3'd3, // unsigned divide
    op_mthi  = 3'd4, // write src_a into HI
    op_mtlo  = 3'd5  // write src_a into LO
  } md_op_e;

  // divider sequencing
  typedef enum logic [1:0] {
    idle   = 2'd0, // waiting for div_start
    run    = 2'd1, // counting out the latency
    finish = 2'd2  // div_done cycle
  } div_state_e;

endpackage

`default_nettype wire

/* logic/md_issue_ctrl.sv */
// issue decode for the md unit; ops are dropped while the divider is busy, unknown op codes too
`timescale 1ns/1ps
`default_nettype none

module md_issue_ctrl (
  input  wire logic                       aclk,
  input  wire logic                       aresetn,
  input  wire logic                       op_valid,
  input  wire md_pkg::md_op_e             op,
  input  wire logic [md_pkg::DATA_W-1:0]  src_a,
  input  wire logic [md_pkg::DATA_W-1:0]  src_b,
  input  wire logic                       div_busy,
  output logic                            mul_start,
  output logic                            mul_signed,
  output logic                            div_start,
  output logic                            div_signed,
  output logic [md_pkg::DATA_W-1:0]       op_a,
  output logic [md_pkg::DATA_W-1:0]       op_b,
  output logic                            wr_hi,
  output logic                            wr_lo,
  output logic [md_pkg::DATA_W-1:0]       wr_data,
  output logic                            busy
);

  logic accept;
  logic hi_sel; // direct write to HI this cycle
  logic lo_sel;

  assign accept = op_valid & ~div_busy; // issuer must hold off while busy
  assign op_a   = src_a;
  assign op_b   = src_b;
  assign busy   = div_busy; // only the divider blocks issue

  always_comb
  begin
    mul_start  = 1'b0;
    mul_signed = 1'b0;
    div_start  = 1'b0;
    div_signed = 1'b0;
    hi_sel     = 1'b0;
    lo_sel     = 1'b0;
    if (accept)
    begin
      case (op)
        md_pkg::op_mult:
        begin
          mul_start  = 1'b1;
          mul_signed = 1'b1;
        end
        md_pkg::op_multu: mul_start = 1'b1;
        md_pkg::op_div:
        begin
          div_start  = 1'b1;
          div_signed = 1'b1;
        end
        md_pkg::op_divu: div_start = 1'b1;
        md_pkg::op_mthi: hi_sel    = 1'b1;
        md_pkg::op_mtlo: lo_sel    = 1'b1;
        default: ; // unknown op, nothing starts
      endcase
    end
  end

  // one-cycle path for HI/LO writes
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_hi <= 1'b0;
      wr_lo <= 1'b0;
    end
    else
    begin
      wr_hi <= hi_sel;
      wr_lo <= lo_sel;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (hi_sel || lo_sel)
      wr_data <= src_a;
  end

endmodule

`default_nettype wire

/* logic/md_multiplier.sv */
// pipelined 32x32 multiplier; MUL_LATENCY must be at least 2, mul_valid comes MUL_LATENCY-1 edges after issue
`timescale 1ns/1ps
`default_nettype none

module md_multiplier #(
  parameter int MUL_LATENCY = 3
) (
  input  wire logic                       aclk,
  input  wire logic                       aresetn,
  input  wire logic                       mul_start,
  input  wire logic                       mul_signed,
  input  wire logic [md_pkg::DATA_W-1:0]  op_a,
  input  wire logic [md_pkg::DATA_W-1:0]  op_b,
  output logic                            mul_valid,
  output logic [md_pkg::PROD_W-1:0]       mul_prod
);

  // operand register plus product stages, last stage feeds the HI/LO commit
  localparam int STAGES = MUL_LATENCY - 1;

  logic signed [md_pkg::EXT_W-1:0]  a_q;
  logic signed [md_pkg::EXT_W-1:0]  b_q;
  logic                             op_vld_q;
  logic signed [md_pkg::PROD_W-1:0] prod_full;
  logic [md_pkg::PROD_W-1:0]        prod_q [STAGES];
  logic [STAGES-1:0]                vld_q;

  // extend to 33 bits so one signed multiply serves both modes
  always_ff @(posedge aclk)
  begin
    a_q <= {mul_signed & op_a[md_pkg::DATA_W-1], op_a};
    b_q <= {mul_signed & op_b[md_pkg::DATA_W-1], op_b};
  end

  assign prod_full = a_q * b_q; // low 64 bits are exact for both modes

  always_ff @(posedge aclk)
  begin
    prod_q[0] <= prod_full;
    for (int i = 1; i < STAGES; i++)
    begin
      prod_q[i] <= prod_q[i-1];
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      op_vld_q <= 1'b0;
      vld_q    <= '0;
    end
    else
    begin
      op_vld_q <= mul_start;
      vld_q[0] <= op_vld_q;
      for (int i = 1; i < STAGES; i++)
      begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  assign mul_valid = vld_q[STAGES-1];
  assign mul_prod  = prod_q[STAGES-1];

endmodule

`default_nettype wire

/* logic/md_divider.sv */
// one divide at a time with fixed DIV_LATENCY (at least 3); x/0 gives all ones and rem = dividend
`timescale 1ns/1ps
`default_nettype none

module md_divider #(
  parameter int DIV_LATENCY = 12
) (
  input  wire logic                       aclk,
  input  wire logic                       aresetn,
  input  wire logic                       div_start,
  input  wire logic                       div_signed,
  input  wire logic [md_pkg::DATA_W-1:0]  op_a,
  input  wire logic [md_pkg::DATA_W-1:0]  op_b,
  output logic                            div_busy,
  output logic                            div_done,
  output logic [md_pkg::DATA_W-1:0]       div_quot,
  output logic [md_pkg::DATA_W-1:0]       div_rem
);

  localparam int CNT_W = $clog2(DIV_LATENCY);

  md_pkg::div_state_e         state_q;
  logic [CNT_W-1:0]           cnt_q;
  logic                       last;
  logic [md_pkg::DATA_W-1:0]  a_q; // dividend
  logic [md_pkg::DATA_W-1:0]  b_q; // divisor
  logic                       signed_q;
  logic                       neg_a;
  logic                       neg_b;
  logic [md_pkg::DATA_W-1:0]  mag_a;
  logic [md_pkg::DATA_W-1:0]  mag_b;
  logic [md_pkg::DATA_W-1:0]  uq;
  logic [md_pkg::DATA_W-1:0]  ur;
  logic [md_pkg::DATA_W-1:0]  quot_c;
  logic [md_pkg::DATA_W-1:0]  rem_c;
  logic                       div_zero;
  logic                       overflow;

  assign last     = (state_q == md_pkg::run) && (cnt_q == CNT_W'(DIV_LATENCY - 2));
  assign div_busy = (state_q != md_pkg::idle);

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state_q  <= md_pkg::idle;
      cnt_q    <= '0;
      div_done <= 1'b0;
    end
    else
    begin
      case (state_q)
        md_pkg::idle:
        begin
          div_done <= 1'b0;
          cnt_q    <= '0;
          if (div_start)
            state_q <= md_pkg::run;
        end
        md_pkg::run:
        begin
          cnt_q <= cnt_q + 1'b1; // reaches DIV_LATENCY-1 with done
          if (last)
          begin
            state_q  <= md_pkg::finish;
            div_done <= 1'b1;
          end
        end
        md_pkg::finish:
        begin
          div_done <= 1'b0;
          state_q  <= md_pkg::idle; // busy drops with the HI/LO commit
        end
        default: state_q <= md_pkg::idle;
      endcase
    end
  end

  // divide on magnitudes, then restore signs
  assign neg_a = signed_q & a_q[md_pkg::DATA_W-1];
  assign neg_b = signed_q & b_q[md_pkg::DATA_W-1];
  assign mag_a = neg_a ? -a_q : a_q;
  assign mag_b = neg_b ? -b_q : b_q;
  assign uq    = mag_a / mag_b;
  assign ur    = mag_a % mag_b;

  assign div_zero = (b_q == '0);
  assign overflow = signed_q && (a_q == {1'b1, {(md_pkg::DATA_W-1){1'b0}}}) && (b_q == '1);

  always_comb
  begin
    if (div_zero)
    begin
      quot_c = '1;
      rem_c  = a_q;
    end
    else if (overflow)
    begin
      quot_c = a_q; // most negative / -1 wraps to itself
      rem_c  = '0;
    end
    else
    begin
      quot_c = (neg_a ^ neg_b) ? -uq : uq; // truncates toward zero
      rem_c  = neg_a ? -ur : ur;           // sign of the dividend
    end
  end

  always_ff @(posedge aclk)
  begin
    if (div_start && (state_q == md_pkg::idle))
    begin
      a_q      <= op_a;
      b_q      <= op_b;
      signed_q <= div_signed;
    end
    if (last)
    begin
      div_quot <= quot_c;
      div_rem  <= rem_c;
    end
  end

endmodule

`default_nettype wire

/* logic/hilo_regs.sv */
// HI/LO pair; arithmetic commits take priority over a direct write on the same edge
`timescale 1ns/1ps
`default_nettype none

module hilo_regs (
  input  wire logic                       aclk,
  input  wire logic                       aresetn,
  input  wire logic                       mul_valid,
  input  wire logic [md_pkg::PROD_W-1:0]  mul_prod,
  input  wire logic                       div_done,
  input  wire logic [md_pkg::DATA_W-1:0]  div_quot,
  input  wire logic [md_pkg::DATA_W-1:0]  div_rem,
  input  wire logic                       wr_hi,
  input  wire logic                       wr_lo,
  input  wire logic [md_pkg::DATA_W-1:0]  wr_data,
  output logic [md_pkg::DATA_W-1:0]       hi,
  output logic [md_pkg::DATA_W-1:0]       lo,
  output logic                            done
);

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      hi   <= '0;
      lo   <= '0;
      done <= 1'b0;
    end
    else if (mul_valid)
    begin
      hi   <= mul_prod[md_pkg::PROD_W-1:md_pkg::DATA_W];
      lo   <= mul_prod[md_pkg::DATA_W-1:0];
      done <= 1'b1;
    end
    else if (div_done)
    begin
      hi   <= div_rem;
      lo   <= div_quot;
      done <= 1'b1;
    end
    else
    begin
      done <= 1'b0; // writes never pulse done
      if (wr_hi)
        hi <= wr_data;
      if (wr_lo)
        lo <= wr_data;
    end
  end

endmodule

`default_nettype wire

/* logic/md_unit.sv */
// multiply/divide unit top; DIV_LATENCY must exceed MUL_LATENCY so results commit in issue order
`timescale 1ns/1ps
`default_nettype none

module md_unit #(
  parameter int MUL_LATENCY = 3,
  parameter int DIV_LATENCY = 12
) (
  input  wire logic                       aclk,
  input  wire logic                       aresetn,
  input  wire logic                       op_valid,
  input  wire md_pkg::md_op_e             op,
  input  wire logic [md_pkg::DATA_W-1:0]  src_a,
  input  wire logic [md_pkg::DATA_W-1:0]  src_b,
  output logic                            busy,
  output logic                            done,
  output logic [md_pkg::DATA_W-1:0]       hi,
  output logic [md_pkg::DATA_W-1:0]       lo
);

  logic                       mul_start;
  logic                       mul_signed;
  logic                       div_start;
  logic                       div_signed;
  logic [md_pkg::DATA_W-1:0]  op_a;
  logic [md_pkg::DATA_W-1:0]  op_b;
  logic                       wr_hi;
  logic                       wr_lo;
  logic [md_pkg::DATA_W-1:0]  wr_data;
  logic                       div_busy;
  logic                       mul_valid;
  logic [md_pkg::PROD_W-1:0]  mul_prod;
  logic                       div_done;
  logic [md_pkg::DATA_W-1:0]  div_quot;
  logic [md_pkg::DATA_W-1:0]  div_rem;

  md_issue_ctrl u_issue_ctrl (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .op_valid   (op_valid),
    .op         (op),
    .src_a      (src_a),
    .src_b      (src_b),
    .div_busy   (div_busy),
    .mul_start  (mul_start),
    .mul_signed (mul_signed),
    .div_start  (div_start),
    .div_signed (div_signed),
    .op_a       (op_a),
    .op_b       (op_b),
    .wr_hi      (wr_hi),
    .wr_lo      (wr_lo),
    .wr_data    (wr_data),
    .busy       (busy)
  );

  md_multiplier #(
    .MUL_LATENCY (MUL_LATENCY)
  ) u_multiplier (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .mul_start  (mul_start),
    .mul_signed (mul_signed),
    .op_a       (op_a),
    .op_b       (op_b),
    .mul_valid  (mul_valid),
    .mul_prod   (mul_prod)
  );

  md_divider #(
    .DIV_LATENCY (DIV_LATENCY)
  ) u_divider (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .div_start  (div_start),
    .div_signed (div_signed),
    .op_a       (op_a),
    .op_b       (op_b),
    .div_busy   (div_busy),
    .div_done   (div_done),
    .div_quot   (div_quot),
    .div_rem    (div_rem)
  );

  hilo_regs u_hilo_regs (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .mul_valid (mul_valid),
    .mul_prod  (mul_prod),
    .div_done  (div_done),
    .div_quot  (div_quot),
    .div_rem   (div_rem),
    .wr_hi     (wr_hi),
    .wr_lo     (wr_lo),
    .wr_data   (wr_data),
    .hi        (hi),
    .lo        (lo),
    .done      (done)
  );

endmodule

`default_nettype wire

/* sim/md_clk_gen.sv */
// 4 ns free-running clock; aresetn held low for the first 4 rising edges and released 1 ns after
`timescale 1ns/1ps
`default_nettype none

module md_clk_gen (
  output logic aclk,
  output logic aresetn
);

  initial
  begin
    aclk    = 1'b0;
    aresetn = 1'b0;
    repeat (4) @(posedge aclk);
    #1 aresetn = 1'b1; // released off the edge like other stimulus
  end

  always #2 aclk = ~aclk; // 4 ns period

endmodule

`default_nettype wire

/* sim/md_unit_chk.sv */
// bound to md_unit ports; fail_count is read by the testbench, hi/lo writes land two samples after issue
`timescale 1ns/1ps
`default_nettype none

module md_unit_chk (
  input wire logic                       aclk,
  input wire logic                       aresetn,
  input wire logic                       op_valid,
  input wire md_pkg::md_op_e             op,
  input wire logic                       busy,
  input wire logic                       done,
  input wire logic [md_pkg::DATA_W-1:0]  hi,
  input wire logic [md_pkg::DATA_W-1:0]  lo
);

  int   fail_count = 0;
  logic div_issue;
  logic wr_issue;

  assign div_issue = op_valid && !busy && (op == md_pkg::op_div || op == md_pkg::op_divu);
  assign wr_issue  = op_valid && !busy && (op == md_pkg::op_mthi || op == md_pkg::op_mtlo);

  // divide commit is the only sample where busy has just fallen
  done_single: assert property (@(posedge aclk)
    (!aresetn |=> !done) and (aresetn && done && !busy && $past(busy) |=> !done))
  else
  begin
    $error("done held high after a divide commit or during reset");
    fail_count++;
  end

  busy_after_div: assert property (@(posedge aclk) disable iff (!aresetn)
    $rose(busy) |-> $past(div_issue))
  else
  begin
    $error("busy rose without an accepted divide");
    fail_count++;
  end

  hilo_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    (!done && !$past(wr_issue, 2)) |-> ($stable(hi) && $stable(lo)))
  else
  begin
    $error("hi or lo changed without a commit or a write");
    fail_count++;
  end

endmodule

`default_nettype wire

/* sim/md_unit_tb.sv */
// directed tests on md_unit with default latencies; stops at the first mismatch or timeout
`timescale 1ns/1ps
`default_nettype none

module md_unit_tb;

  logic                       aclk;
  logic                       aresetn;
  logic                       op_valid;
  md_pkg::md_op_e             op;
  logic [md_pkg::DATA_W-1:0]  src_a;
  logic [md_pkg::DATA_W-1:0]  src_b;
  logic                       busy;
  logic                       done;
  logic [md_pkg::DATA_W-1:0]  hi;
  logic [md_pkg::DATA_W-1:0]  lo;

  int                         seed;
  int                         mul_lat;
  int                         div_lat;
  logic [md_pkg::DATA_W-1:0]  model_hi; // last value HI should hold
  logic [md_pkg::DATA_W-1:0]  model_lo;

  md_clk_gen u_clk_gen (
    .aclk    (aclk),
    .aresetn (aresetn)
  );

  md_unit u_md_unit (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .op_valid (op_valid),
    .op       (op),
    .src_a    (src_a),
    .src_b    (src_b),
    .busy     (busy),
    .done     (done),
    .hi       (hi),
    .lo       (lo)
  );

  bind md_unit md_unit_chk u_md_unit_chk (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .op_valid (op_valid),
    .op       (op),
    .busy     (busy),
    .done     (done),
    .hi       (hi),
    .lo       (lo)
  );

  task automatic stop_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic abort_run(input string why);
    $display("%s at time %0t", why, $time);
    stop_run();
  endtask

  always @(posedge aclk)
  begin
    if (u_md_unit.u_md_unit_chk.fail_count != 0)
      abort_run("assertion failure in the bound checker");
  end

  task automatic check_reg(input string name, input logic [md_pkg::DATA_W-1:0] exp_val,
                           input logic [md_pkg::DATA_W-1:0] act_val);
    if (act_val !== exp_val)
    begin
      $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
               $time, name, exp_val, act_val);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val)
    begin
      $display("CHECK FAILED time=%0t signal=%s expected=%b actual=%b",
               $time, name, exp_val, act_val);
      stop_run();
    end
  endtask

  task automatic step();
    @(posedge aclk);
    #1; // outputs settled, inputs may change
  endtask

  // holds op_valid over one rising edge, returns 1 ns after it
  task automatic issue(input md_pkg::md_op_e o, input logic [md_pkg::DATA_W-1:0] a,
                       input logic [md_pkg::DATA_W-1:0] b);
    op_valid = 1'b1;
    op       = o;
    src_a    = a;
    src_b    = b;
    @(posedge aclk);
    #1;
    op_valid = 1'b0;
  endtask

  task automatic wait_done(input int limit, input logic check_busy, output int cycles);
    cycles = 0;
    while (!done)
    begin
      if (check_busy)
        check_bit("busy", 1'b1, busy);
      if (cycles >= limit)
        abort_run("timeout waiting for done");
      else
      begin
        step();
        cycles++;
      end
    end
    if (check_busy)
      check_bit("busy", 1'b0, busy); // falls with the commit
  endtask

  // {HI, LO} for a multiply
  function automatic logic [md_pkg::PROD_W-1:0] mul_model(input logic [md_pkg::DATA_W-1:0] a,
      input logic [md_pkg::DATA_W-1:0] b, input logic sgn);
    logic [md_pkg::PROD_W-1:0] ea;
    logic [md_pkg::PROD_W-1:0] eb;
    ea = sgn ? {{md_pkg::DATA_W{a[md_pkg::DATA_W-1]}}, a} : {{md_pkg::DATA_W{1'b0}}, a};
    eb = sgn ? {{md_pkg::DATA_W{b[md_pkg::DATA_W-1]}}, b} : {{md_pkg::DATA_W{1'b0}}, b};
    return ea * eb; // modulo 2^64 equals the signed product
  endfunction

  // {HI, LO} = {remainder, quotient}
  function automatic logic [md_pkg::PROD_W-1:0] div_model(input logic [md_pkg::DATA_W-1:0] a,
      input logic [md_pkg::DATA_W-1:0] b, input logic sgn);
    longint                    sa;
    longint                    sb;
    logic [md_pkg::DATA_W-1:0] q;
    logic [md_pkg::DATA_W-1:0] r;
    sa = $signed(a);
    sb = $signed(b);
    if (b == '0)
    begin
      q = '1;
      r = a;
    end
    else if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff)
    begin
      q = a;
      r = '0;
    end
    else if (sgn)
    begin
      q = md_pkg::DATA_W'(sa / sb); // truncates toward zero
      r = md_pkg::DATA_W'(sa % sb); // sign of the dividend
    end
    else
    begin
      q = a / b;
      r = a % b;
    end
    return {r, q};
  endfunction

  task automatic run_mul(input logic [md_pkg::DATA_W-1:0] a, input logic [md_pkg::DATA_W-1:0] b,
                         input logic sgn);
    logic [md_pkg::PROD_W-1:0] exp_prod;
    int                        cycles;
    exp_prod = mul_model(a, b, sgn);
    issue(sgn ? md_pkg::op_mult : md_pkg::op_multu, a, b);
    wait_done(mul_lat + 4, 1'b0, cycles);
    check_reg("mul latency", mul_lat, cycles);
    check_reg("hi", exp_prod[md_pkg::PROD_W-1:md_pkg::DATA_W], hi);
    check_reg("lo", exp_prod[md_pkg::DATA_W-1:0], lo);
    model_hi = exp_prod[md_pkg::PROD_W-1:md_pkg::DATA_W];
    model_lo = exp_prod[md_pkg::DATA_W-1:0];
    step();
    check_bit("done", 1'b0, done); // single-cycle pulse
  endtask

  task automatic run_div(input logic [md_pkg::DATA_W-1:0] a, input logic [md_pkg::DATA_W-1:0] b,
                         input logic sgn);
    logic [md_pkg::PROD_W-1:0] exp_res;
    int                        cycles;
    exp_res = div_model(a, b, sgn);
    issue(sgn ? md_pkg::op_div : md_pkg::op_divu, a, b);
    wait_done(div_lat + 4, 1'b1, cycles);
    check_reg("div latency", div_lat, cycles);
    check_reg("hi", exp_res[md_pkg::PROD_W-1:md_pkg::DATA_W], hi);
    check_reg("lo", exp_res[md_pkg::DATA_W-1:0], lo);
    model_hi = exp_res[md_pkg::PROD_W-1:md_pkg::DATA_W];
    model_lo = exp_res[md_pkg::DATA_W-1:0];
    step();
  endtask

  task automatic run_write(input logic to_hi, input logic [md_pkg::DATA_W-1:0] val);
    issue(to_hi ? md_pkg::op_mthi : md_pkg::op_mtlo, val, ~val);
    check_bit("done", 1'b0, done);
    step();
    if (to_hi)
      model_hi = val;
    else
      model_lo = val;
    check_reg("hi", model_hi, hi);
    check_reg("lo", model_lo, lo);
    check_bit("done", 1'b0, done);
    step();
    check_bit("done", 1'b0, done);
  endtask

  task automatic test_multiply();
    logic [md_pkg::DATA_W-1:0] a;
    logic [md_pkg::DATA_W-1:0] b;
    run_mul(32'd3, 32'd5, 1'b1);
    run_mul(32'hffff_fff9, 32'hffff_fff7, 1'b1); // -7 x -9
    run_mul(32'hffff_ffff, 32'hffff_ffff, 1'b1);
    run_mul(32'hffff_ffff, 32'hffff_ffff, 1'b0);
    run_mul(32'h8000_0000, 32'h8000_0000, 1'b1);
    run_mul(32'h7fff_ffff, 32'h8000_0000, 1'b0);
    for (int i = 0; i < 20; i++)
    begin
      a = $random(seed);
      b = $random(seed);
      run_mul(a, b, 1'b1);
      run_mul(a, b, 1'b0);
    end
  endtask

  task automatic test_divide();
    logic [md_pkg::DATA_W-1:0] a;
    logic [md_pkg::DATA_W-1:0] b;
    for (int i = 0; i < 20; i++)
    begin
      a = $random(seed);
      b = $random(seed);
      if (i % 2)
        b = {{24{b[7]}}, b[7:0]}; // small divisor, larger quotients
      if (b == '0)
        b = 32'd7;
      run_div(a, b, 1'b1);
      run_div(a, b, 1'b0);
    end
  endtask

  task automatic test_div_corners();
    run_div(32'd1234, 32'd0, 1'b1);
    run_div(32'hffff_fffb, 32'd0, 1'b1);
    run_div(32'hdead_beef, 32'd0, 1'b0);
    run_div(32'h8000_0000, 32'hffff_ffff, 1'b1);
    run_div(32'h8000_0000, 32'hffff_ffff, 1'b0); // plain unsigned case
  endtask

  task automatic test_writes();
    run_write(1'b1, 32'h1357_9bdf);
    run_write(1'b0, 32'h2468_ace0);
    run_write(1'b1, 32'h0000_0000);
  endtask

  task automatic test_back_to_back();
    logic [md_pkg::PROD_W-1:0] exp_q [$];
    logic [md_pkg::PROD_W-1:0] e;
    logic [md_pkg::DATA_W-1:0] a;
    logic [md_pkg::DATA_W-1:0] b;
    int                        cycles;
    for (int i = 0; i < 4; i++)
    begin
      a = $random(seed);
      b = $random(seed);
      exp_q.push_back(mul_model(a, b, i[0]));
      issue(i[0] ? md_pkg::op_mult : md_pkg::op_multu, a, b);
    end
    cycles = 0;
    while (exp_q.size() > 0)
    begin
      if (done)
      begin
        e = exp_q.pop_front(); // commits in issue order
        check_reg("hi", e[md_pkg::PROD_W-1:md_pkg::DATA_W], hi);
        check_reg("lo", e[md_pkg::DATA_W-1:0], lo);
        model_hi = e[md_pkg::PROD_W-1:md_pkg::DATA_W];
        model_lo = e[md_pkg::DATA_W-1:0];
      end
      if (cycles > mul_lat + 8)
        abort_run("timeout waiting for back-to-back multiply results");
      else
      begin
        step();
        cycles++;
      end
    end
    check_bit("done", 1'b0, done);
  endtask

  task automatic test_issue_while_busy();
    logic [md_pkg::PROD_W-1:0] exp_div;
    int                        cycles;
    exp_div = div_model(32'd1000, 32'hffff_fff9, 1'b1);
    issue(md_pkg::op_div, 32'd1000, 32'hffff_fff9);
    check_bit("busy", 1'b1, busy);
    issue(md_pkg::op_mult, 32'h1234, 32'h5678); // dropped
    issue(md_pkg::op_mthi, 32'hdead_beef, 32'h0);
    wait_done(div_lat + 4, 1'b1, cycles);
    check_reg("div latency", div_lat - 2, cycles); // two edges spent on ignored issues
    check_reg("hi", exp_div[md_pkg::PROD_W-1:md_pkg::DATA_W], hi);
    check_reg("lo", exp_div[md_pkg::DATA_W-1:0], lo);
    run_mul(32'hffff_fffe, 32'd21, 1'b1);
  endtask

  initial
  begin
    int cycles;
    op_valid = 1'b0;
    op       = md_pkg::op_mult;
    src_a    = '0;
    src_b    = '0;
    seed     = 32'h3a53b48c;
    mul_lat  = u_md_unit.MUL_LATENCY;
    div_lat  = u_md_unit.DIV_LATENCY;
    model_hi = '0;
    model_lo = '0;
    cycles   = 0;
    while (aresetn !== 1'b1)
    begin
      if (cycles > 20)
        abort_run("reset was never released");
      else
      begin
        @(posedge aclk);
        cycles++;
      end
    end
    step();
    check_reg("hi", '0, hi);
    check_reg("lo", '0, lo);
    check_bit("busy", 1'b0, busy);
    check_bit("done", 1'b0, done);
    test_multiply();
    test_divide();
    test_div_corners();
    test_writes();
    test_back_to_back();
    test_issue_while_busy();
    if (u_md_unit.u_md_unit_chk.fail_count == 0)
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
    else
    begin
      $display("%0d assertion failures in the bound checker",
               u_md_unit.u_md_unit_chk.fail_count);
      stop_run();
    end
  end

endmodule

`default_nettype wire

/* files.f */
logic/md_pkg.sv
logic/md_issue_ctrl.sv
logic/md_multiplier.sv
logic/md_divider.sv
logic/hilo_regs.sv
logic/md_unit.sv
sim/md_clk_gen.sv
sim/md_unit_chk.sv
sim/md_unit_tb.sv

/* Bender.yml */
package:
  name: md_unit

sources:
  - logic/md_pkg.sv
  - logic/md_issue_ctrl.sv
  - logic/md_multiplier.sv
  - logic/md_divider.sv
  - logic/hilo_regs.sv
  - logic/md_unit.sv
  - target: simulation
    files:
      - sim/md_clk_gen.sv
      - sim/md_unit_chk.sv
      - sim/md_unit_tb.sv
